//--- all.f
uart_pkg.sv
uart_tx_fifo.sv
uart_tx.sv
uart_rx.sv
uart_ctrl.sv
uart_subsys.sv
tb_uart_subsys.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_uart_subsys -f all.f -o tb_uart_subsys_sim

./obj_dir/tb_uart_subsys_sim | tee sim.log

if grep -q 'All tests passed!' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb_uart_subsys.sv
`timescale 1ns/10ps

module tb_uart_subsys;

    localparam int FIFO_DEPTH = 4;
    localparam int BDW        = uart_pkg::UART_BAUD_DIV_SIZE;
    localparam int NUM_LOOP   = 200;
    localparam int MAX_DIV    = 20;
    // Loopback, two timing runs, deferred config and the framing frame
    localparam int NUM_BYTES  = NUM_LOOP + 3 + 3 + 5 + 1;
    localparam int WATCHDOG_CYCLES = NUM_BYTES * 11 * MAX_DIV + 1000;

    logic                                clk;
    logic                                rst_n;
    logic                                cmd_valid;
    logic [uart_pkg::UART_CMD_SIZE-1:0]  cmd;
    logic                                credit;
    logic                                tx_pin;
    logic                                rx_pin;
    logic                                rx_valid;
    logic [uart_pkg::UART_DATA_SIZE-1:0] rx_data;
    logic                                rx_frame_err;
    logic                                force_mode;
    logic                                force_pin;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [31:0] rng;
    int          pushed;
    int          seq_errors;
    int          cur_div;
    int          returned   = 0;
    int          rx_cnt     = 0;
    int          mon_errors = 0;
    int          cyc        = 0;
    int          last_fall  = 0;
    logic        tx_prev    = 1'b1;
    // Expected bytes with the frame error flag on top
    logic [8:0]  exp_q[$];
    int          fall_q[$];
    int          low_q[$];

    uart_subsys #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .RESET_BAUD_DIV (16)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_valid_i    (cmd_valid),
        .cmd_i          (cmd),
        .credit_o       (credit),
        .tx_pin_o       (tx_pin),
        .rx_pin_i       (rx_pin),
        .rx_valid_o     (rx_valid),
        .rx_data_o      (rx_data),
        .rx_frame_err_o (rx_frame_err)
    );

    // Loopback unless a frame is driven by hand
    assign rx_pin = force_mode ? force_pin : tx_pin;

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        rng = xorshift(rng);
        return lo + int'(rng % (hi - lo + 1));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rst_n && credit) begin
            returned++;
            assert (FIFO_DEPTH - pushed + returned <= FIFO_DEPTH) else begin
                mon_errors++;
                $display("[FAIL] %0t: host credits %0d above depth", $time,
                         FIFO_DEPTH - pushed + returned);
            end
        end
        if (rst_n && rx_valid) begin
            assert (rx_cnt < exp_q.size()) else begin
                mon_errors++;
                $display("At %0t the receiver gave a byte that was never sent", $time);
            end
            if (rx_cnt < exp_q.size()) begin
                assert ({rx_frame_err, rx_data} == exp_q[rx_cnt]) else begin
                    mon_errors++;
                    $display("[FAIL] %0t: rx err/data %h, expected %h", $time,
                             {rx_frame_err, rx_data}, exp_q[rx_cnt]);
                end
                rx_cnt++;
            end
        end
    end

    // Start bit edges and low widths on the line
    always @(negedge clk) begin
        cyc++;
        if (tx_prev && !tx_pin) begin
            fall_q.push_back(cyc);
            last_fall = cyc;
        end else if (!tx_prev && tx_pin) begin
            low_q.push_back(cyc - last_fall);
        end
        tx_prev = tx_pin;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_data(input logic [7:0] b);
        uart_pkg::uart_cmd_u c;
        c = '0;
        c.data_view.data = b;
        while (FIFO_DEPTH - pushed + returned == 0) begin
            @(negedge clk);
        end
        cmd_valid = 1'b1;
        cmd       = c;
        pushed++;
        exp_q.push_back({1'b0, b});
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_cfg(input int div, input logic two_stop);
        uart_pkg::uart_cmd_u c;
        c = '0;
        c.cfg_view.kind     = 1'b1;
        c.cfg_view.two_stop = two_stop;
        c.cfg_view.baud_div = BDW'(div);
        cmd_valid = 1'b1;
        cmd       = c;
        cur_div   = div;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (rx_cnt != exp_q.size()) begin
            @(negedge clk);
        end
        // Rest of the stop bits after the mid-stop sample
        repeat (2 * cur_div + 4) @(negedge clk);
    endtask

    task automatic drive_bit(input logic b);
        force_pin = b;
        repeat (cur_div) @(negedge clk);
    endtask

    task automatic check_frames(input int first, input int count, input int div,
                                input int bits);
        int i;
        assert (low_q.size() >= first + count) else begin
            seq_errors++;
            $display("At %0t fewer than %0d frames were seen on tx_pin_o", $time, count);
        end
        for (i = first; i < first + count && i < low_q.size(); i++) begin
            assert (low_q[i] == div) else begin
                seq_errors++;
                $display("[FAIL] %0t: start bit %0d cycles, expected %0d", $time,
                         low_q[i], div);
            end
            if (i > first) begin
                assert (fall_q[i] - fall_q[i-1] == bits * div) else begin
                    seq_errors++;
                    $display("[FAIL] %0t: frame spacing %0d, expected %0d", $time,
                             fall_q[i] - fall_q[i-1], bits * div);
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int         i;
        int         base;
        int         d1;
        int         d2;
        logic       two2;
        logic [7:0] fbyte;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        force_mode = 1'b0;
        force_pin  = 1'b1;
        rng        = 32'd97572;
        pushed     = 0;
        seq_errors = 0;
        cur_div    = 16;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Quiet line after reset
        assert (tx_pin === 1'b1 && credit === 1'b0) else begin
            seq_errors++;
            $display("[FAIL] %0t: tx_pin_o %b credit_o %b after reset", $time, tx_pin, credit);
        end
        repeat (50) @(negedge clk);

        // Random loopback with a config now and then
        for (i = 0; i < NUM_LOOP; i++) begin
            if (i % 50 == 25) begin
                send_cfg(rand_range(4, MAX_DIV), rand_range(0, 1) != 0);
            end
            send_data(8'(rand_range(0, 255)));
            repeat (rand_range(0, 3)) @(negedge clk);
        end
        wait_idle();

        // All-ones bytes give one falling edge per frame
        d1 = rand_range(4, MAX_DIV);
        send_cfg(d1, 1'b0);
        base = fall_q.size();
        repeat (3) send_data(8'hFF);
        wait_idle();
        check_frames(base, 3, d1, 10);
        d2 = rand_range(4, MAX_DIV);
        send_cfg(d2, 1'b1);
        base = fall_q.size();
        repeat (3) send_data(8'hFF);
        wait_idle();
        check_frames(base, 3, d2, 11);

        // Config lands behind three queued bytes
        d1 = rand_range(4, MAX_DIV);
        send_cfg(d1, 1'b0);
        d2   = 4 + (d1 - 4 + rand_range(1, 16)) % 17;
        two2 = rand_range(0, 1) != 0;
        base = fall_q.size();
        repeat (3) send_data(8'hFF);
        send_cfg(d2, two2);
        repeat (2) send_data(8'hFF);
        wait_idle();
        check_frames(base, 3, d1, 10);
        check_frames(base + 3, 2, d2, two2 ? 11 : 10);

        // Hand-made frame with a low stop bit
        fbyte = 8'(rand_range(0, 255));
        exp_q.push_back({1'b1, fbyte});
        force_mode = 1'b1;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(fbyte[i]);
        end
        drive_bit(1'b0);
        force_pin = 1'b1;
        wait_idle();
        force_mode = 1'b0;

        assert (returned == pushed) else begin
            seq_errors++;
            $display("[FAIL] %0t: %0d credits returned for %0d data words", $time,
                     returned, pushed);
        end
        $display("Errors: %0d in sequence checks, %0d in monitor checks", seq_errors,
                 mon_errors);
        if (seq_errors + mon_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- uart_ctrl.sv
`timescale 1ns/10ps

module uart_ctrl #(
    parameter int unsigned FIFO_DEPTH     = 4,
    parameter int unsigned RESET_BAUD_DIV = 16
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cmd_valid_i,
    input  logic [uart_pkg::UART_CMD_SIZE-1:0]      cmd_i,
    output logic                                    credit_o,
    output logic                                    fifo_push_o,
    output logic [uart_pkg::UART_DATA_SIZE-1:0]     fifo_wdata_o,
    output logic                                    fifo_pop_o,
    input  logic                                    fifo_empty_i,
    input  logic [uart_pkg::UART_DATA_SIZE-1:0]     fifo_rdata_i,
    output logic                                    tx_start_o,
    output logic [uart_pkg::UART_DATA_SIZE-1:0]     tx_data_o,
    input  logic                                    tx_ready_i,
    output logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0] baud_div_o,
    output logic                                    two_stop_o
);

    localparam int BDW    = uart_pkg::UART_BAUD_DIV_SIZE;
    localparam int FILL_W = $clog2(FIFO_DEPTH + 1);

    uart_pkg::uart_cmd_u    cmd;
    logic                   is_data_word;
    logic                   is_cfg_word;
    logic                   has_room;
    logic                   tx_start;
    logic                   cfg_apply;
    logic [FILL_W-1:0]      fill_q;
    logic [FILL_W-1:0]      ahead_q;
    logic                   pend_q;
    logic [BDW-1:0]         pend_baud_q;
    logic                   pend_two_stop_q;
    logic [BDW-1:0]         baud_div_q;
    logic                   two_stop_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cmd          = cmd_i;
    assign is_data_word = cmd_valid_i && !cmd.data_view.kind;
    assign is_cfg_word  = cmd_valid_i && cmd.cfg_view.kind;
    // Room left means the host still held a credit
    assign has_room     = (fill_q != FILL_W'(FIFO_DEPTH));

    assign fifo_push_o  = is_data_word && has_room;
    assign fifo_wdata_o = cmd.data_view.data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame start and credit return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bytes queued ahead of a pending config still go out on the old settings
    assign tx_start   = tx_ready_i && !fifo_empty_i && (!pend_q || (ahead_q != '0));
    assign tx_start_o = tx_start;
    assign tx_data_o  = fifo_rdata_i;
    assign fifo_pop_o = tx_start;
    assign credit_o   = tx_start;

    assign cfg_apply  = pend_q && (ahead_q == '0) && tx_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_q     <= '0;
            ahead_q    <= '0;
            pend_q     <= 1'b0;
            baud_div_q <= BDW'(RESET_BAUD_DIV);
            two_stop_q <= 1'b0;
        end else begin
            case ({fifo_push_o, tx_start})
                2'b10:   fill_q <= fill_q + FILL_W'(1);
                2'b01:   fill_q <= fill_q - FILL_W'(1);
                default: fill_q <= fill_q;
            endcase
            if (is_cfg_word) begin
                pend_q  <= 1'b1;
                ahead_q <= fill_q - FILL_W'(tx_start);
            end else begin
                if (cfg_apply) begin
                    pend_q <= 1'b0;
                end
                if (tx_start && pend_q) begin
                    ahead_q <= ahead_q - FILL_W'(1);
                end
            end
            if (cfg_apply) begin
                baud_div_q <= pend_baud_q;
                two_stop_q <= pend_two_stop_q;
            end
        end
    end

    // Pending config payload
    always_ff @(posedge clk) begin
        if (is_cfg_word) begin
            pend_baud_q     <= cmd.cfg_view.baud_div;
            pend_two_stop_q <= cmd.cfg_view.two_stop;
        end
    end

    assign baud_div_o = baud_div_q;
    assign two_stop_o = two_stop_q;

endmodule

//--- uart_pkg.sv
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    parameter int UART_DATA_SIZE      = 8;
    parameter int UART_BAUD_DIV_SIZE  = 12;
    parameter int UART_CMD_SIZE       = 16;
    // Holds a frame length of up to 11 bits
    parameter int UART_FRAME_CNT_SIZE = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        UART_TX_IDLE,
        UART_TX_START,
        UART_TX_DATA
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        UART_RX_IDLE,
        UART_RX_START,
        UART_RX_DATA,
        UART_RX_STOP
    } uart_rx_state_e;

    // Host command word, bit 15 selects the view
    typedef union packed {
        struct packed {
            logic                      kind;
            logic [6:0]                spare;
            logic [UART_DATA_SIZE-1:0] data;
        } data_view;
        struct packed {
            logic                          kind;
            logic [1:0]                    unused;
            logic                          two_stop;
            logic [UART_BAUD_DIV_SIZE-1:0] baud_div;
        } cfg_view;
    } uart_cmd_u;

endpackage

//--- uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    rx_pin_i,
    input  logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0] baud_div_i,
    output logic                                    rx_valid_o,
    output logic [uart_pkg::UART_DATA_SIZE-1:0]     rx_data_o,
    output logic                                    rx_frame_err_o
);

    localparam int BDW   = uart_pkg::UART_BAUD_DIV_SIZE;
    localparam int IDX_W = $clog2(uart_pkg::UART_DATA_SIZE);

    uart_pkg::uart_rx_state_e               state_q, state_d;
    logic [BDW-1:0]                         sample_cnt_q, sample_cnt_d;
    logic [IDX_W-1:0]                       bit_idx_q, bit_idx_d;
    logic [uart_pkg::UART_DATA_SIZE-1:0]    shift_q;
    logic                                   rx_sync1_q, rx_sync2_q, rx_prev_q;
    logic                                   valid_q, valid_d;
    logic                                   frame_err_q, frame_err_d;
    logic                                   fall_edge;
    logic                                   sample_tick;
    logic                                   shift_en;
    logic [BDW-1:0]                         half_div;

    assign fall_edge   = rx_prev_q && !rx_sync2_q;
    assign sample_tick = (sample_cnt_q == '0);
    assign half_div    = {1'b0, baud_div_i[BDW-1:1]};

    always_comb begin
        state_d      = state_q;
        sample_cnt_d = sample_cnt_q;
        bit_idx_d    = bit_idx_q;
        valid_d      = 1'b0;
        frame_err_d  = frame_err_q;
        shift_en     = 1'b0;
        if (state_q != uart_pkg::UART_RX_IDLE && !sample_tick) begin
            sample_cnt_d = sample_cnt_q - BDW'(1);
        end
        case (state_q)
            uart_pkg::UART_RX_IDLE: begin
                if (fall_edge) begin
                    sample_cnt_d = half_div - BDW'(1);
                    state_d      = uart_pkg::UART_RX_START;
                end
            end
            uart_pkg::UART_RX_START: begin
                // Line back high at mid start bit means a glitch
                if (sample_tick) begin
                    if (!rx_sync2_q) begin
                        sample_cnt_d = baud_div_i - BDW'(1);
                        bit_idx_d    = '0;
                        state_d      = uart_pkg::UART_RX_DATA;
                    end else begin
                        state_d = uart_pkg::UART_RX_IDLE;
                    end
                end
            end
            uart_pkg::UART_RX_DATA: begin
                if (sample_tick) begin
                    shift_en     = 1'b1;
                    sample_cnt_d = baud_div_i - BDW'(1);
                    bit_idx_d    = bit_idx_q + IDX_W'(1);
                    if (bit_idx_q == IDX_W'(uart_pkg::UART_DATA_SIZE - 1)) begin
                        state_d = uart_pkg::UART_RX_STOP;
                    end
                end
            end
            uart_pkg::UART_RX_STOP: begin
                if (sample_tick) begin
                    valid_d     = 1'b1;
                    frame_err_d = !rx_sync2_q;
                    state_d     = uart_pkg::UART_RX_IDLE;
                end
            end
            default: begin
                state_d = uart_pkg::UART_RX_IDLE;
            end
        endcase
    end

    // Synchronizer flops idle high like the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync1_q   <= 1'b1;
            rx_sync2_q   <= 1'b1;
            rx_prev_q    <= 1'b1;
            state_q      <= uart_pkg::UART_RX_IDLE;
            sample_cnt_q <= '0;
            bit_idx_q    <= '0;
            valid_q      <= 1'b0;
            frame_err_q  <= 1'b0;
        end else begin
            rx_sync1_q   <= rx_pin_i;
            rx_sync2_q   <= rx_sync1_q;
            rx_prev_q    <= rx_sync2_q;
            state_q      <= state_d;
            sample_cnt_q <= sample_cnt_d;
            bit_idx_q    <= bit_idx_d;
            valid_q      <= valid_d;
            frame_err_q  <= frame_err_d;
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_q <= {rx_sync2_q, shift_q[uart_pkg::UART_DATA_SIZE-1:1]};
        end
    end

    assign rx_valid_o     = valid_q;
    assign rx_data_o      = shift_q;
    assign rx_frame_err_o = frame_err_q;

endmodule

//--- uart_subsys.sv
`timescale 1ns/10ps

module uart_subsys #(
    parameter int unsigned FIFO_DEPTH     = 4,
    parameter int unsigned RESET_BAUD_DIV = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cmd_valid_i,
    input  logic [uart_pkg::UART_CMD_SIZE-1:0]  cmd_i,
    output logic                                credit_o,
    output logic                                tx_pin_o,
    input  logic                                rx_pin_i,
    output logic                                rx_valid_o,
    output logic [uart_pkg::UART_DATA_SIZE-1:0] rx_data_o,
    output logic                                rx_frame_err_o
);

    logic                                    fifo_push;
    logic [uart_pkg::UART_DATA_SIZE-1:0]     fifo_wdata;
    logic                                    fifo_pop;
    logic                                    fifo_empty;
    logic [uart_pkg::UART_DATA_SIZE-1:0]     fifo_rdata;
    logic                                    tx_start;
    logic [uart_pkg::UART_DATA_SIZE-1:0]     tx_data;
    logic                                    tx_ready;
    logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0] baud_div;
    logic                                    two_stop;

    uart_ctrl #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .RESET_BAUD_DIV (RESET_BAUD_DIV)
    ) i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .credit_o     (credit_o),
        .fifo_push_o  (fifo_push),
        .fifo_wdata_o (fifo_wdata),
        .fifo_pop_o   (fifo_pop),
        .fifo_empty_i (fifo_empty),
        .fifo_rdata_i (fifo_rdata),
        .tx_start_o   (tx_start),
        .tx_data_o    (tx_data),
        .tx_ready_i   (tx_ready),
        .baud_div_o   (baud_div),
        .two_stop_o   (two_stop)
    );

    // Full flag unused here, credits keep the FIFO from overflowing
    uart_tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (fifo_push),
        .wdata_i (fifo_wdata),
        .pop_i   (fifo_pop),
        .rdata_o (fifo_rdata),
        .empty_o (fifo_empty),
        .full_o  ()
    );

    uart_tx i_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (tx_start),
        .data_i     (tx_data),
        .baud_div_i (baud_div),
        .two_stop_i (two_stop),
        .ready_o    (tx_ready),
        .tx_pin_o   (tx_pin_o)
    );

    uart_rx i_rx (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_pin_i       (rx_pin_i),
        .baud_div_i     (baud_div),
        .rx_valid_o     (rx_valid_o),
        .rx_data_o      (rx_data_o),
        .rx_frame_err_o (rx_frame_err_o)
    );

endmodule

//--- uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start_i,
    input  logic [uart_pkg::UART_DATA_SIZE-1:0]     data_i,
    input  logic [uart_pkg::UART_BAUD_DIV_SIZE-1:0] baud_div_i,
    input  logic                                    two_stop_i,
    output logic                                    ready_o,
    output logic                                    tx_pin_o
);

    localparam int BDW = uart_pkg::UART_BAUD_DIV_SIZE;
    localparam int FCW = uart_pkg::UART_FRAME_CNT_SIZE;

    uart_pkg::uart_tx_state_e               state_q, state_d;
    logic [BDW-1:0]                         sample_cnt_q, sample_cnt_d;
    logic [FCW-1:0]                         bit_cnt_q, bit_cnt_d;
    logic [uart_pkg::UART_DATA_SIZE-1:0]    shifter_q, shifter_d;
    logic [FCW-1:0]                         frame_len;
    logic                                   sample_tick;

    // Start + 8 data + stop bits
    assign frame_len   = two_stop_i ? FCW'(11) : FCW'(10);
    assign sample_tick = (sample_cnt_q == '0);

    always_comb begin
        state_d      = state_q;
        sample_cnt_d = sample_cnt_q;
        bit_cnt_d    = bit_cnt_q;
        shifter_d    = shifter_q;
        case (state_q)
            uart_pkg::UART_TX_IDLE: begin
                if (start_i) begin
                    shifter_d    = data_i;
                    bit_cnt_d    = frame_len;
                    sample_cnt_d = baud_div_i - BDW'(1);
                    state_d      = uart_pkg::UART_TX_START;
                end
            end
            uart_pkg::UART_TX_START, uart_pkg::UART_TX_DATA: begin
                if (sample_tick) begin
                    bit_cnt_d = bit_cnt_q - FCW'(1);
                    // No shift at the end of the start bit, data bit 0 is already at the LSB
                    if (state_q == uart_pkg::UART_TX_DATA) begin
                        shifter_d = {1'b1, shifter_q[uart_pkg::UART_DATA_SIZE-1:1]};
                    end
                    state_d = uart_pkg::UART_TX_DATA;
                    if (bit_cnt_q == FCW'(1)) begin
                        state_d = uart_pkg::UART_TX_IDLE;
                    end else if (bit_cnt_q == FCW'(2)) begin
                        // Last stop bit ends with the idle cycle
                        sample_cnt_d = baud_div_i - BDW'(2);
                    end else begin
                        sample_cnt_d = baud_div_i - BDW'(1);
                    end
                end else begin
                    sample_cnt_d = sample_cnt_q - BDW'(1);
                end
            end
            default: begin
                state_d = uart_pkg::UART_TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= uart_pkg::UART_TX_IDLE;
            sample_cnt_q <= '0;
            bit_cnt_q    <= '0;
        end else begin
            state_q      <= state_d;
            sample_cnt_q <= sample_cnt_d;
            bit_cnt_q    <= bit_cnt_d;
        end
    end

    always_ff @(posedge clk) begin
        shifter_q <= shifter_d;
    end

    assign ready_o  = (state_q == uart_pkg::UART_TX_IDLE) && (bit_cnt_q == '0);
    // Stop bits come from the ones shifted in
    assign tx_pin_o = (state_q == uart_pkg::UART_TX_START) ? 1'b0 :
                      (state_q == uart_pkg::UART_TX_DATA)  ? shifter_q[0] : 1'b1;

endmodule

//--- uart_tx_fifo.sv
`timescale 1ns/10ps

module uart_tx_fifo #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                push_i,
    input  logic [uart_pkg::UART_DATA_SIZE-1:0] wdata_i,
    input  logic                                pop_i,
    output logic [uart_pkg::UART_DATA_SIZE-1:0] rdata_o,
    output logic                                empty_o,
    output logic                                full_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [uart_pkg::UART_DATA_SIZE-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]                    wr_ptr_q;
    logic [PTR_W-1:0]                    rd_ptr_q;
    logic [CNT_W-1:0]                    count_q;
    logic                                do_push;
    logic                                do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
    // Head entry always visible
    assign rdata_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule
